// File: source/noc_settings.svh
/* Mesh size, flit field widths, input buffer depth and router port count */
`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

// Grid size, row 0 is the north edge and column 0 the west edge
`define NOC_ROWS 2
`define NOC_COLS 2
`define NOC_ROW_BITS 1
`define NOC_COL_BITS 1
`define NOC_NODE_BITS (`NOC_ROW_BITS + `NOC_COL_BITS)

`define NOC_FLIT_WIDTH 32

// Flits per input buffer, also the credits a sender starts with
`define NOC_BUFFER_DEPTH 4
`define NOC_PTR_BITS 2
`define NOC_CREDIT_BITS 3

`define NOC_PORTS 5

`endif

// File: source/noc_pkg.sv
/* Flit field types, node coordinate types, port and arbiter state enums */
`include "noc_settings.svh"

package noc_pkg;

    typedef logic [`NOC_FLIT_WIDTH-1:0] flit_data_t;
    typedef logic [`NOC_ROW_BITS-1:0] row_t;
    typedef logic [`NOC_COL_BITS-1:0] col_t;

    // Row index in the upper bits, column index in the lower bits
    typedef logic [`NOC_NODE_BITS-1:0] node_id_t;

    typedef logic [`NOC_CREDIT_BITS-1:0] credit_count_t;

    typedef enum logic [2:0] {
        PORT_LOCAL = 3'd0,
        PORT_NORTH = 3'd1,
        PORT_SOUTH = 3'd2,
        PORT_EAST  = 3'd3,
        PORT_WEST  = 3'd4
    } port_t;

    typedef enum logic {ARB_IDLE, ARB_LOCKED} arb_state_t;

endpackage

// File: source/flit_buffer.sv
/* Input flit FIFO, circular with read/write pointers and a fill count,
   returns one credit pulse for every flit popped */
`timescale 1ns/10ps
`include "noc_settings.svh"

module flit_buffer
    import noc_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    input  logic       send_in,
    input  flit_data_t data_in,
    input  node_id_t   dest_in,
    input  logic       is_tail_in,

    input  logic       pop,
    output logic       valid,
    output flit_data_t data,
    output node_id_t   dest,
    output logic       is_tail,

    output logic       credit_out
);

    flit_data_t mem_data [`NOC_BUFFER_DEPTH];
    node_id_t   mem_dest [`NOC_BUFFER_DEPTH];
    logic       mem_tail [`NOC_BUFFER_DEPTH];

    logic [`NOC_PTR_BITS-1:0] wr_ptr;
    logic [`NOC_PTR_BITS-1:0] rd_ptr;
    credit_count_t            count;
    logic                     read;

    assign valid   = (count != '0);
    assign read    = pop && valid;
    assign data    = mem_data[rd_ptr];
    assign dest    = mem_dest[rd_ptr];
    assign is_tail = mem_tail[rd_ptr];

    // Storage
    always_ff @(posedge clk) begin
        if (send_in) begin
            mem_data[wr_ptr] <= data_in;
            mem_dest[wr_ptr] <= dest_in;
            mem_tail[wr_ptr] <= is_tail_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_out <= 1'b0;
        end else begin
            if (send_in) begin
                wr_ptr <= (wr_ptr == `NOC_PTR_BITS'(`NOC_BUFFER_DEPTH - 1)) ?
                          '0 : wr_ptr + 1'b1;
            end
            if (read) begin
                rd_ptr <= (rd_ptr == `NOC_PTR_BITS'(`NOC_BUFFER_DEPTH - 1)) ?
                          '0 : rd_ptr + 1'b1;
            end
            count      <= count + credit_count_t'(send_in) - credit_count_t'(read);
            // Slot freed, hand the credit back upstream
            credit_out <= read;
        end
    end

    // The upstream credit counter must keep writes away from a full buffer
    assert property (@(posedge clk) disable iff (reset)
        send_in |-> (count < credit_count_t'(`NOC_BUFFER_DEPTH)));

endmodule

// File: source/route_compute.sv
/* Route stage, one registered flit with its XY output port */
`timescale 1ns/10ps
`include "noc_settings.svh"

module route_compute
    import noc_pkg::*;
#(
    parameter int    ROW     = 0,
    parameter int    COL     = 0,
    parameter port_t IN_PORT = PORT_LOCAL
) (
    input  logic       clk,
    input  logic       reset,

    input  logic       valid_in,
    input  flit_data_t data_in,
    input  node_id_t   dest_in,
    input  logic       is_tail_in,
    output logic       pop,

    output logic       valid,
    output flit_data_t data,
    output node_id_t   dest,
    output logic       is_tail,
    output port_t      out_port,
    input  logic       grant
);

    row_t  dest_row;
    col_t  dest_col;
    port_t next_port;

    assign dest_row = dest_in[`NOC_NODE_BITS-1 -: `NOC_ROW_BITS];
    assign dest_col = dest_in[`NOC_COL_BITS-1:0];

    // Column first, then row
    always_comb begin
        if (dest_col > col_t'(COL))
            next_port = PORT_EAST;
        else if (dest_col < col_t'(COL))
            next_port = PORT_WEST;
        else if (dest_row > row_t'(ROW))
            next_port = PORT_SOUTH;
        else if (dest_row < row_t'(ROW))
            next_port = PORT_NORTH;
        else
            next_port = PORT_LOCAL;
    end

    // Take a new flit when empty or when the held one leaves this cycle
    assign pop = valid_in && (!valid || grant);

    always_ff @(posedge clk) begin
        if (pop) begin
            data     <= data_in;
            dest     <= dest_in;
            is_tail  <= is_tail_in;
            out_port <= next_port;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            valid <= 1'b0;
        else if (pop)
            valid <= 1'b1;
        else if (grant)
            valid <= 1'b0;
    end

    // An endpoint must not address itself
    assert property (@(posedge clk) disable iff (reset)
        (IN_PORT == PORT_LOCAL) && pop |=> (out_port != PORT_LOCAL));

endmodule

// File: source/output_arbiter.sv
/* Output port arbiter, round robin with a lock held from head to tail,
   downstream credit counter and the registered output flit */
`timescale 1ns/10ps
`include "noc_settings.svh"

module output_arbiter
    import noc_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    input  logic [`NOC_PORTS-1:0] request,
    input  flit_data_t            req_data [`NOC_PORTS],
    input  node_id_t              req_dest [`NOC_PORTS],
    input  logic                  req_tail [`NOC_PORTS],
    output logic [`NOC_PORTS-1:0] grant,

    output logic                  send_out,
    output flit_data_t            data_out,
    output node_id_t              dest_out,
    output logic                  is_tail_out,
    input  logic                  credit_in
);

    arb_state_t    state;
    port_t         owner;
    port_t         last_winner;
    port_t         pick;
    logic          pick_valid;
    credit_count_t credits;
    logic          granted;

    // Next requester after the last winner
    always_comb begin
        int idx;
        pick       = last_winner;
        pick_valid = 1'b0;
        for (int k = 1; k <= `NOC_PORTS; k++) begin
            idx = (int'(last_winner) + k) % `NOC_PORTS;
            if (!pick_valid && request[idx]) begin
                pick       = port_t'(idx);
                pick_valid = 1'b1;
            end
        end
    end

    always_comb begin
        grant = '0;
        if (state == ARB_LOCKED && credits != '0)
            grant[owner] = request[owner];
    end

    assign granted = |grant;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= ARB_IDLE;
            owner       <= PORT_LOCAL;
            last_winner <= PORT_LOCAL;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (pick_valid) begin
                        state       <= ARB_LOCKED;
                        owner       <= pick;
                        last_winner <= pick;
                    end
                end
                ARB_LOCKED: begin
                    // Release once the tail has gone through
                    if (granted && req_tail[owner])
                        state <= ARB_IDLE;
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            credits  <= credit_count_t'(`NOC_BUFFER_DEPTH);
            send_out <= 1'b0;
        end else begin
            credits  <= credits + credit_count_t'(credit_in) - credit_count_t'(granted);
            send_out <= granted;
        end
    end

    always_ff @(posedge clk) begin
        if (granted) begin
            data_out    <= req_data[owner];
            dest_out    <= req_dest[owner];
            is_tail_out <= req_tail[owner];
        end
    end

    // Downstream never hands back more credits than its buffer holds
    assert property (@(posedge clk) disable iff (reset)
        credits <= credit_count_t'(`NOC_BUFFER_DEPTH));

endmodule

// File: source/router.sv
/* Five-port wormhole router, input buffers feeding route stages
   feeding one output arbiter per port */
`timescale 1ns/10ps
`include "noc_settings.svh"

module router
    import noc_pkg::*;
#(
    parameter int ROW = 0,
    parameter int COL = 0
) (
    input  logic       clk,
    input  logic       reset,

    input  flit_data_t data_in     [`NOC_PORTS],
    input  node_id_t   dest_in     [`NOC_PORTS],
    input  logic       is_tail_in  [`NOC_PORTS],
    input  logic       send_in     [`NOC_PORTS],
    output logic       credit_out  [`NOC_PORTS],

    output flit_data_t data_out    [`NOC_PORTS],
    output node_id_t   dest_out    [`NOC_PORTS],
    output logic       is_tail_out [`NOC_PORTS],
    output logic       send_out    [`NOC_PORTS],
    input  logic       credit_in   [`NOC_PORTS]
);

    // Buffer to route stage
    logic                  buf_valid [`NOC_PORTS];
    flit_data_t            buf_data  [`NOC_PORTS];
    node_id_t              buf_dest  [`NOC_PORTS];
    logic                  buf_tail  [`NOC_PORTS];
    logic                  rc_pop    [`NOC_PORTS];

    // Route stage to arbiters
    logic [`NOC_PORTS-1:0] rc_valid;
    flit_data_t            rc_data   [`NOC_PORTS];
    node_id_t              rc_dest   [`NOC_PORTS];
    logic                  rc_tail   [`NOC_PORTS];
    port_t                 rc_port   [`NOC_PORTS];
    logic [`NOC_PORTS-1:0] rc_grant;

    // Indexed [output][input]
    logic [`NOC_PORTS-1:0] request   [`NOC_PORTS];
    logic [`NOC_PORTS-1:0] grant     [`NOC_PORTS];

    always_comb begin
        for (int o = 0; o < `NOC_PORTS; o++) begin
            for (int i = 0; i < `NOC_PORTS; i++) begin
                request[o][i] = rc_valid[i] && (rc_port[i] == port_t'(o));
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `NOC_PORTS; i++) begin
            rc_grant[i] = 1'b0;
            for (int o = 0; o < `NOC_PORTS; o++) begin
                rc_grant[i] = rc_grant[i] | grant[o][i];
            end
        end
    end

    for (genvar p = 0; p < `NOC_PORTS; p++) begin : g_port
        flit_buffer u_buffer (
            .clk        (clk),
            .reset      (reset),
            .send_in    (send_in[p]),
            .data_in    (data_in[p]),
            .dest_in    (dest_in[p]),
            .is_tail_in (is_tail_in[p]),
            .pop        (rc_pop[p]),
            .valid      (buf_valid[p]),
            .data       (buf_data[p]),
            .dest       (buf_dest[p]),
            .is_tail    (buf_tail[p]),
            .credit_out (credit_out[p])
        );

        route_compute #(.ROW(ROW), .COL(COL), .IN_PORT(port_t'(p))) u_route (
            .clk        (clk),
            .reset      (reset),
            .valid_in   (buf_valid[p]),
            .data_in    (buf_data[p]),
            .dest_in    (buf_dest[p]),
            .is_tail_in (buf_tail[p]),
            .pop        (rc_pop[p]),
            .valid      (rc_valid[p]),
            .data       (rc_data[p]),
            .dest       (rc_dest[p]),
            .is_tail    (rc_tail[p]),
            .out_port   (rc_port[p]),
            .grant      (rc_grant[p])
        );

        output_arbiter u_arbiter (
            .clk         (clk),
            .reset       (reset),
            .request     (request[p]),
            .req_data    (rc_data),
            .req_dest    (rc_dest),
            .req_tail    (rc_tail),
            .grant       (grant[p]),
            .send_out    (send_out[p]),
            .data_out    (data_out[p]),
            .dest_out    (dest_out[p]),
            .is_tail_out (is_tail_out[p]),
            .credit_in   (credit_in[p])
        );
    end

endmodule

// File: source/mesh.sv
/* Mesh top level, router grid with neighbor links and tied-off edge ports */
`timescale 1ns/10ps
`include "noc_settings.svh"

module mesh
    import noc_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    input  flit_data_t data_in     [`NOC_ROWS][`NOC_COLS],
    input  node_id_t   dest_in     [`NOC_ROWS][`NOC_COLS],
    input  logic       is_tail_in  [`NOC_ROWS][`NOC_COLS],
    input  logic       send_in     [`NOC_ROWS][`NOC_COLS],
    output logic       credit_out  [`NOC_ROWS][`NOC_COLS],

    output flit_data_t data_out    [`NOC_ROWS][`NOC_COLS],
    output node_id_t   dest_out    [`NOC_ROWS][`NOC_COLS],
    output logic       is_tail_out [`NOC_ROWS][`NOC_COLS],
    output logic       send_out    [`NOC_ROWS][`NOC_COLS],
    input  logic       credit_in   [`NOC_ROWS][`NOC_COLS]
);

    flit_data_t r_data_in     [`NOC_ROWS][`NOC_COLS][`NOC_PORTS];
    node_id_t   r_dest_in     [`NOC_ROWS][`NOC_COLS][`NOC_PORTS];
    logic       r_is_tail_in  [`NOC_ROWS][`NOC_COLS][`NOC_PORTS];
    logic       r_send_in     [`NOC_ROWS][`NOC_COLS][`NOC_PORTS];
    logic       r_credit_out  [`NOC_ROWS][`NOC_COLS][`NOC_PORTS];
    flit_data_t r_data_out    [`NOC_ROWS][`NOC_COLS][`NOC_PORTS];
    node_id_t   r_dest_out    [`NOC_ROWS][`NOC_COLS][`NOC_PORTS];
    logic       r_is_tail_out [`NOC_ROWS][`NOC_COLS][`NOC_PORTS];
    logic       r_send_out    [`NOC_ROWS][`NOC_COLS][`NOC_PORTS];
    logic       r_credit_in   [`NOC_ROWS][`NOC_COLS][`NOC_PORTS];

    for (genvar r = 0; r < `NOC_ROWS; r++) begin : g_row
        for (genvar c = 0; c < `NOC_COLS; c++) begin : g_col
            router #(.ROW(r), .COL(c)) u_router (
                .clk         (clk),
                .reset       (reset),
                .data_in     (r_data_in[r][c]),
                .dest_in     (r_dest_in[r][c]),
                .is_tail_in  (r_is_tail_in[r][c]),
                .send_in     (r_send_in[r][c]),
                .credit_out  (r_credit_out[r][c]),
                .data_out    (r_data_out[r][c]),
                .dest_out    (r_dest_out[r][c]),
                .is_tail_out (r_is_tail_out[r][c]),
                .send_out    (r_send_out[r][c]),
                .credit_in   (r_credit_in[r][c])
            );

            // Endpoint on the local port
            assign r_data_in[r][c][PORT_LOCAL]    = data_in[r][c];
            assign r_dest_in[r][c][PORT_LOCAL]    = dest_in[r][c];
            assign r_is_tail_in[r][c][PORT_LOCAL] = is_tail_in[r][c];
            assign r_send_in[r][c][PORT_LOCAL]    = send_in[r][c];
            assign r_credit_in[r][c][PORT_LOCAL]  = credit_in[r][c];
            assign credit_out[r][c]  = r_credit_out[r][c][PORT_LOCAL];
            assign data_out[r][c]    = r_data_out[r][c][PORT_LOCAL];
            assign dest_out[r][c]    = r_dest_out[r][c][PORT_LOCAL];
            assign is_tail_out[r][c] = r_is_tail_out[r][c][PORT_LOCAL];
            assign send_out[r][c]    = r_send_out[r][c][PORT_LOCAL];

            // Each input takes the facing output of its neighbor
            for (genvar p = 1; p < `NOC_PORTS; p++) begin : g_link
                localparam int NR = (p == PORT_SOUTH) ? r + 1 : (p == PORT_NORTH) ? r - 1 : r;
                localparam int NC = (p == PORT_EAST) ? c + 1 : (p == PORT_WEST) ? c - 1 : c;
                localparam int OPP = (p == PORT_NORTH) ? PORT_SOUTH :
                                     (p == PORT_SOUTH) ? PORT_NORTH :
                                     (p == PORT_EAST)  ? PORT_WEST  : PORT_EAST;

                if (NR >= 0 && NR < `NOC_ROWS && NC >= 0 && NC < `NOC_COLS) begin : g_inner
                    assign r_data_in[r][c][p]    = r_data_out[NR][NC][OPP];
                    assign r_dest_in[r][c][p]    = r_dest_out[NR][NC][OPP];
                    assign r_is_tail_in[r][c][p] = r_is_tail_out[NR][NC][OPP];
                    assign r_send_in[r][c][p]    = r_send_out[NR][NC][OPP];
                    assign r_credit_in[r][c][p]  = r_credit_out[NR][NC][OPP];
                end else begin : g_edge
                    assign r_data_in[r][c][p]    = '0;
                    assign r_dest_in[r][c][p]    = '0;
                    assign r_is_tail_in[r][c][p] = 1'b0;
                    assign r_send_in[r][c][p]    = 1'b0;
                    assign r_credit_in[r][c][p]  = 1'b0;
                end
            end
        end
    end

endmodule

// File: tests/mesh_checks.svh
/* Scoreboard of expected flits per source and destination, packet contiguity
   tracking and the typed compare tasks of the mesh testbench */
`ifndef MESH_CHECKS_SVH
`define MESH_CHECKS_SVH

// Indexed [source][destination]
flit_data_t exp_data [NODES][NODES][$];
logic       exp_tail [NODES][NODES][$];

// Source of the packet being delivered at each destination
logic in_packet [NODES];
int   cur_src   [NODES];

int total_queued;
int total_received;

task automatic check_data(input string name, input flit_data_t exp, input flit_data_t act);
    checks++;
    if (act !== exp) begin
        $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        errors++;
    end
endtask

task automatic check_dest(input string name, input node_id_t exp, input node_id_t act);
    checks++;
    if (act !== exp) begin
        $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
        errors++;
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
        $display("ERROR at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        errors++;
    end
endtask

task automatic check_count(input string name, input credit_count_t exp,
                           input credit_count_t act);
    checks++;
    if (act !== exp) begin
        $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
        errors++;
    end
endtask

task automatic check_total(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
        $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
        errors++;
    end
endtask

task automatic expect_flit(input int src, input int dst, input flit_data_t data,
                           input logic tail);
    exp_data[src][dst].push_back(data);
    exp_tail[src][dst].push_back(tail);
    total_queued++;
endtask

// Source id rides in the top data bits
task automatic receive_flit(input int node, input flit_data_t data, input node_id_t dest,
                            input logic tail);
    int src;
    src = int'(data[`NOC_FLIT_WIDTH-1 -: 4]);
    check_dest($sformatf("dest_out[%0d]", node), node_id_t'(node), dest);
    if (src >= NODES || exp_data[src][node].size() == 0) begin
        $display("At %0t ns node %0d received flit %h that no source sent to it",
                 $time, node, data);
        errors++;
        return;
    end
    if (in_packet[node] && src != cur_src[node]) begin
        $display("At %0t ns node %0d got a flit of node %0d inside a packet of node %0d",
                 $time, node, src, cur_src[node]);
        errors++;
    end
    check_data($sformatf("data_out[%0d]", node), exp_data[src][node].pop_front(), data);
    check_bit($sformatf("is_tail_out[%0d]", node), exp_tail[src][node].pop_front(), tail);
    in_packet[node] = !tail;
    cur_src[node]   = src;
    total_received++;
endtask

`endif

// File: tests/mesh_tb.sv
/* Mesh testbench with clock, reset, per-node packet generators, credit
   return model, watchdog and the test sequence */
`timescale 1ns/10ps
`include "noc_settings.svh"

module mesh_tb
    import noc_pkg::*;
();

    localparam int NODES       = `NOC_ROWS * `NOC_COLS;
    localparam int CLK_PERIOD  = 20;
    localparam int PACKETS     = 12;
    localparam int MAX_LEN     = 4;
    localparam int MAX_FLITS   = NODES * (NODES - 1) + 2 * NODES * PACKETS * MAX_LEN;
    localparam int WATCHDOG    = MAX_FLITS * 40 + 2000;
    localparam int DRAIN_LIMIT = 4000;

    logic       clk;
    logic       reset;
    flit_data_t data_in     [`NOC_ROWS][`NOC_COLS];
    node_id_t   dest_in     [`NOC_ROWS][`NOC_COLS];
    logic       is_tail_in  [`NOC_ROWS][`NOC_COLS];
    logic       send_in     [`NOC_ROWS][`NOC_COLS];
    logic       credit_out  [`NOC_ROWS][`NOC_COLS];
    flit_data_t data_out    [`NOC_ROWS][`NOC_COLS];
    node_id_t   dest_out    [`NOC_ROWS][`NOC_COLS];
    logic       is_tail_out [`NOC_ROWS][`NOC_COLS];
    logic       send_out    [`NOC_ROWS][`NOC_COLS];
    logic       credit_in   [`NOC_ROWS][`NOC_COLS];

    int errors;
    int checks;
    bit traffic_started;

    // Generator side, one flit queue and credit count per node
    flit_data_t gen_data [NODES][$];
    node_id_t   gen_dest [NODES][$];
    logic       gen_tail [NODES][$];
    int         credits  [NODES];
    int         sent     [NODES];
    int         pulses   [NODES];

    // Delivery side credit return
    int   pending_ret [NODES];
    int   outstanding [NODES];
    logic withheld    [NODES];

    `include "mesh_checks.svh"

    mesh dut (
        .clk         (clk),
        .reset       (reset),
        .data_in     (data_in),
        .dest_in     (dest_in),
        .is_tail_in  (is_tail_in),
        .send_in     (send_in),
        .credit_out  (credit_out),
        .data_out    (data_out),
        .dest_out    (dest_out),
        .is_tail_out (is_tail_out),
        .send_out    (send_out),
        .credit_in   (credit_in)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic queue_packet(input int src, input int dst, input int len);
        flit_data_t d;
        for (int i = 0; i < len; i++) begin
            d = {4'(src), 28'($urandom)};
            gen_data[src].push_back(d);
            gen_dest[src].push_back(node_id_t'(dst));
            gen_tail[src].push_back(i == len - 1);
            expect_flit(src, dst, d, i == len - 1);
        end
    endtask

    task automatic queue_random_traffic();
        for (int src = 0; src < NODES; src++) begin
            for (int p = 0; p < PACKETS; p++) begin
                queue_packet(src, (src + 1 + $urandom % (NODES - 1)) % NODES,
                             1 + $urandom % MAX_LEN);
            end
        end
    endtask

    // Outputs are registered, so they are sampled before the new inputs go out
    task automatic cycle_step();
        int r;
        int c;
        for (int n = 0; n < NODES; n++) begin
            r = n / `NOC_COLS;
            c = n % `NOC_COLS;
            if (!traffic_started) begin
                check_bit($sformatf("send_out[%0d]", n), 1'b0, send_out[r][c]);
                check_bit($sformatf("credit_out[%0d]", n), 1'b0, credit_out[r][c]);
            end
            if (credit_out[r][c]) begin
                pulses[n]++;
                credits[n]++;
                if (credits[n] > `NOC_BUFFER_DEPTH) begin
                    $display("At %0t ns node %0d got back more credits than it sent flits",
                             $time, n);
                    errors++;
                end
            end
            if (send_out[r][c]) begin
                receive_flit(n, data_out[r][c], dest_out[r][c], is_tail_out[r][c]);
                pending_ret[n]++;
                outstanding[n]++;
                if (outstanding[n] > `NOC_BUFFER_DEPTH) begin
                    $display("At %0t ns node %0d shows %0d sends without a returned credit",
                             $time, n, outstanding[n]);
                    errors++;
                end
            end
            if (pending_ret[n] > 0 && !withheld[n] && $urandom % 4 != 0) begin
                credit_in[r][c] = 1'b1;
                pending_ret[n]--;
                outstanding[n]--;
            end else begin
                credit_in[r][c] = 1'b0;
            end
            if (gen_data[n].size() > 0 && credits[n] > 0 && $urandom % 4 != 0) begin
                send_in[r][c]    = 1'b1;
                data_in[r][c]    = gen_data[n].pop_front();
                dest_in[r][c]    = gen_dest[n].pop_front();
                is_tail_in[r][c] = gen_tail[n].pop_front();
                credits[n]--;
                sent[n]++;
                traffic_started = 1'b1;
            end else begin
                send_in[r][c] = 1'b0;
            end
        end
    endtask

    always begin
        @(posedge clk);
        #2;
        cycle_step();
    end

    function automatic bit drained();
        bit done;
        done = (total_received == total_queued);
        for (int n = 0; n < NODES; n++) begin
            if (pending_ret[n] != 0 || gen_data[n].size() != 0)
                done = 1'b0;
        end
        return done;
    endfunction

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (!drained() && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (!drained()) begin
            $display("At %0t ns traffic did not drain within %0d cycles", $time, DRAIN_LIMIT);
            errors++;
        end
        repeat (8) @(posedge clk);
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("[%0t ns] test %s finished with %0d errors", $time, name, errors - errs_before);
    endtask

    initial begin
        #(WATCHDOG * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles with traffic still pending", WATCHDOG);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int errs;
        int bp;
        int hold;
        void'($urandom(41633));
        clk   = 1'b0;
        reset = 1'b1;
        for (int n = 0; n < NODES; n++) begin
            data_in[n / `NOC_COLS][n % `NOC_COLS]    = '0;
            dest_in[n / `NOC_COLS][n % `NOC_COLS]    = '0;
            is_tail_in[n / `NOC_COLS][n % `NOC_COLS] = 1'b0;
            send_in[n / `NOC_COLS][n % `NOC_COLS]    = 1'b0;
            credit_in[n / `NOC_COLS][n % `NOC_COLS]  = 1'b0;
            credits[n]     = `NOC_BUFFER_DEPTH;
            sent[n]        = 0;
            pulses[n]      = 0;
            pending_ret[n] = 0;
            outstanding[n] = 0;
            withheld[n]    = 1'b0;
            in_packet[n]   = 1'b0;
            cur_src[n]     = 0;
        end

        errs = errors;
        repeat (16) @(posedge clk);
        #2 reset = 1'b0;
        repeat (8) @(posedge clk);
        report_test("reset_idle", errs);

        errs = errors;
        for (int src = 0; src < NODES; src++) begin
            for (int dst = 0; dst < NODES; dst++) begin
                if (dst != src)
                    queue_packet(src, dst, 1);
            end
        end
        wait_drain();
        report_test("single_flit", errs);

        errs = errors;
        queue_random_traffic();
        wait_drain();
        report_test("random_traffic", errs);

        // Hold back the delivery credits of one node for a while
        errs = errors;
        bp   = $urandom % NODES;
        hold = 200 + $urandom % 400;
        withheld[bp] = 1'b1;
        queue_random_traffic();
        repeat (hold) @(posedge clk);
        withheld[bp] = 1'b0;
        wait_drain();
        report_test("back_pressure", errs);

        errs = errors;
        for (int n = 0; n < NODES; n++) begin
            check_count($sformatf("generator credits[%0d]", n),
                        credit_count_t'(`NOC_BUFFER_DEPTH), credit_count_t'(credits[n]));
            check_total($sformatf("credit_out pulses[%0d]", n), sent[n], pulses[n]);
            for (int dst = 0; dst < NODES; dst++) begin
                if (exp_data[n][dst].size() != 0) begin
                    $display("Flits from node %0d to node %0d never arrived", n, dst);
                    errors++;
                end
            end
        end
        check_total("flits received", total_queued, total_received);
        report_test("credit_conservation", errs);

        $display("5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: mesh.f
+incdir+source
+incdir+tests
source/noc_pkg.sv
source/flit_buffer.sv
source/route_compute.sv
source/output_arbiter.sv
source/router.sv
source/mesh.sv
tests/mesh_tb.sv
